//--- cpu_control.sv
`timescale 1ns/10ps

module cpu_control (
    input  logic clk,
    input  logic reset,
    input  logic mem_read,
    input  logic mem_write,
    input  logic inst_ack,
    input  logic data_ack,
    input  logic gr_we,
    output logic inst_cyc,
    output logic inst_stb,
    output logic data_cyc,
    output logic data_stb,
    output logic data_we,
    output logic inst_load,
    output logic result_load,
    output logic mem_load,
    output logic rf_we,
    output logic pc_update
);

    typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB} state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_FETCH;
            inst_cyc <= 1'b0;
            data_cyc <= 1'b0;
            data_we  <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (inst_cyc && inst_ack) begin
                        inst_cyc <= 1'b0;
                        state    <= S_DECODE;
                    end else begin
                        inst_cyc <= 1'b1; // the first fetch after reset opens here.
                    end
                end
                S_DECODE: state <= S_EXEC;
                S_EXEC: begin
                    if (mem_read || mem_write) begin
                        data_cyc <= 1'b1; // address is in the result register from now on.
                        data_we  <= mem_write;
                        state    <= S_MEM;
                    end else begin
                        state <= S_WB;
                    end
                end
                S_MEM: begin
                    if (data_ack) begin
                        data_cyc <= 1'b0;
                        data_we  <= 1'b0;
                        state    <= S_WB;
                    end
                end
                S_WB: begin
                    inst_cyc <= 1'b1;
                    state    <= S_FETCH;
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    assign inst_stb    = inst_cyc;
    assign data_stb    = data_cyc;
    assign inst_load   = (state == S_FETCH) && inst_cyc && inst_ack;
    assign result_load = (state == S_EXEC);
    assign mem_load    = (state == S_MEM) && data_ack && !data_we;
    assign rf_we       = (state == S_WB) && gr_we;
    assign pc_update   = (state == S_WB);

    // ########################################
    // bus protocol checks.
    // ########################################
    // only one bus is ever in a cycle at a time.
    assert property (@(posedge clk) disable iff (reset) $rose(inst_stb) |-> !data_cyc);
    assert property (@(posedge clk) disable iff (reset) $rose(data_stb) |-> !inst_cyc);

    assert property (@(posedge clk) disable iff (reset) inst_cyc && inst_ack |=> !inst_cyc);
    assert property (@(posedge clk) disable iff (reset) data_cyc && data_ack |=> !data_cyc);

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    // ########################################
    // alu operation codes.
    // ########################################
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_NOR  = 4'd5;
    localparam alu_op_t ALU_OR   = 4'd6;
    localparam alu_op_t ALU_XOR  = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    localparam alu_op_t ALU_LUI  = 4'd11; // passes operand 2 through.

    // how the next pc is formed once the instruction retires.
    typedef enum logic [2:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_JIRL
    } branch_kind_t;

    localparam word_t RESET_PC_DEFAULT = 32'h1c00_0000;

endpackage

//--- cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic           clk,
    input  logic           reset,
    // instruction bus, read only.
    output logic           inst_cyc,
    output logic           inst_stb,
    output cpu_pkg::word_t inst_adr,
    input  cpu_pkg::word_t inst_rdata,
    input  logic           inst_ack,
    // data bus.
    output logic           data_cyc,
    output logic           data_stb,
    output logic           data_we,
    output cpu_pkg::word_t data_adr,
    output cpu_pkg::word_t data_wdata,
    input  cpu_pkg::word_t data_rdata,
    input  logic           data_ack,
    // retirement trace, valid in the write-back cycle.
    output cpu_pkg::word_t debug_wb_pc,
    output logic [3:0]     debug_wb_rf_we,
    output logic [4:0]     debug_wb_rf_wnum,
    output cpu_pkg::word_t debug_wb_rf_wdata
);

    import cpu_pkg::*;

    alu_op_t      alu_op;
    logic         src1_is_pc;
    logic         src2_is_imm;
    logic         mem_read;
    logic         mem_write;
    logic         gr_we;
    word_t        imm;
    word_t        br_offs;
    branch_kind_t branch_kind;
    reg_addr_t    raddr1;
    reg_addr_t    raddr2;
    reg_addr_t    dest;
    word_t        rdata1;
    word_t        rdata2;
    word_t        pc;
    word_t        wb_data;
    logic         inst_load;
    logic         result_load;
    logic         mem_load;
    logic         rf_we;
    logic         pc_update;

    cpu_control u_cpu_control (.*);

    inst_decoder u_inst_decoder (.*);

    regfile u_regfile (.we(rf_we), .waddr(dest), .wdata(wb_data), .*);

    exec_unit u_exec_unit (.*);

    pc_unit #(.RESET_PC(RESET_PC)) u_pc_unit (.*);

    assign inst_adr          = pc;
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

//--- exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::alu_op_t alu_op,
    input  logic             src1_is_pc,
    input  logic             src2_is_imm,
    input  cpu_pkg::word_t   pc,
    input  cpu_pkg::word_t   rdata1,
    input  cpu_pkg::word_t   rdata2,
    input  cpu_pkg::word_t   imm,
    input  logic             result_load,
    input  logic             mem_load,
    input  logic             mem_read,
    input  cpu_pkg::word_t   data_rdata,
    output cpu_pkg::word_t   data_adr,
    output cpu_pkg::word_t   data_wdata,
    output cpu_pkg::word_t   wb_data
);

    import cpu_pkg::*;

    word_t      src1;
    word_t      src2;
    logic [4:0] shamt;
    word_t      alu_result;
    word_t      result;
    word_t      load_data;

    assign src1  = src1_is_pc ? pc : rdata1;
    assign src2  = src2_is_imm ? imm : rdata2;
    assign shamt = src2[4:0];

    // ########################################
    // alu.
    // ########################################
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = src1 + src2;
            ALU_SUB:  alu_result = src1 - src2;
            ALU_SLT:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: alu_result = {31'b0, src1 < src2};
            ALU_AND:  alu_result = src1 & src2;
            ALU_NOR:  alu_result = ~(src1 | src2);
            ALU_OR:   alu_result = src1 | src2;
            ALU_XOR:  alu_result = src1 ^ src2;
            ALU_SLL:  alu_result = src1 << shamt;
            ALU_SRL:  alu_result = src1 >> shamt;
            ALU_SRA:  alu_result = $signed(src1) >>> shamt;
            ALU_LUI:  alu_result = src2;
            default:  alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (result_load) begin
            result <= alu_result;
        end
        if (mem_load) begin
            load_data <= data_rdata;
        end
    end

    assign data_adr   = result;
    assign data_wdata = rdata2; // rd stays addressed while the store is on the bus.
    assign wb_data    = mem_read ? load_data : result;

    // the control FSM only captures read data for an instruction decoded as a load.
    assert property (@(posedge clk) disable iff (reset) mem_load |-> mem_read);

endmodule

//--- files.f
cpu_pkg.sv
cpu_control.sv
inst_decoder.sv
regfile.sv
exec_unit.sv
pc_unit.sv
cpu_top.sv
tb_clock_gen.sv
tb_cpu_top.sv

//--- inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  inst_load,
    input  cpu_pkg::word_t        inst_rdata,
    output cpu_pkg::alu_op_t      alu_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  gr_we,
    output cpu_pkg::word_t        imm,
    output cpu_pkg::word_t        br_offs,
    output cpu_pkg::branch_kind_t branch_kind,
    output cpu_pkg::reg_addr_t    raddr1,
    output cpu_pkg::reg_addr_t    raddr2,
    output cpu_pkg::reg_addr_t    dest
);

    import cpu_pkg::*;

    word_t inst;
    word_t si12;
    word_t ui5;
    word_t offs16;
    word_t offs26;
    logic  rd_is_src2;

    always_ff @(posedge clk) begin
        if (reset) begin
            inst <= '0; // all zeros matches no instruction.
        end else if (inst_load) begin
            inst <= inst_rdata;
        end
    end

    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign ui5    = {27'b0, inst[14:10]};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    // ########################################
    // opcode decode.
    // ########################################
    always_comb begin
        alu_op      = ALU_ADD;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        gr_we       = 1'b1;
        rd_is_src2  = 1'b0;
        branch_kind = BR_NONE;
        imm         = si12;
        br_offs     = offs16;
        if (inst[31:20] == 12'h001) begin // three-register forms.
            src2_is_imm = 1'b0;
            case (inst[19:15])
                5'h00:   alu_op = ALU_ADD;
                5'h02:   alu_op = ALU_SUB;
                5'h04:   alu_op = ALU_SLT;
                5'h05:   alu_op = ALU_SLTU;
                5'h08:   alu_op = ALU_NOR;
                5'h09:   alu_op = ALU_AND;
                5'h0a:   alu_op = ALU_OR;
                5'h0b:   alu_op = ALU_XOR;
                default: gr_we  = 1'b0;
            endcase
        end else if (inst[31:20] == 12'h004) begin // shifts by a 5-bit immediate.
            imm = ui5;
            case (inst[19:15])
                5'h01:   alu_op = ALU_SLL;
                5'h09:   alu_op = ALU_SRL;
                5'h11:   alu_op = ALU_SRA;
                default: gr_we  = 1'b0;
            endcase
        end else if (inst[31:22] == 10'h00a) begin
            alu_op = ALU_ADD; // addi.w keeps the signed 12-bit immediate.
        end else if (inst[31:25] == 7'h0a) begin
            alu_op = ALU_LUI;
            imm    = {inst[24:5], 12'b0};
        end else if (inst[31:22] == 10'h0a2) begin
            mem_read = 1'b1;
        end else if (inst[31:22] == 10'h0a6) begin
            mem_write  = 1'b1;
            gr_we      = 1'b0;
            rd_is_src2 = 1'b1; // store data comes from rd.
        end else if (inst[31:26] == 6'h13) begin
            src1_is_pc  = 1'b1;
            imm         = 32'd4;
            branch_kind = BR_JIRL;
        end else if (inst[31:26] == 6'h14) begin
            gr_we       = 1'b0;
            branch_kind = BR_B;
            br_offs     = offs26;
        end else if (inst[31:26] == 6'h15) begin
            src1_is_pc  = 1'b1;
            imm         = 32'd4;
            branch_kind = BR_BL;
            br_offs     = offs26;
        end else if (inst[31:27] == 5'h0b) begin // beq and bne differ in bit 26.
            gr_we       = 1'b0;
            rd_is_src2  = 1'b1;
            branch_kind = inst[26] ? BR_BNE : BR_BEQ;
        end else begin
            gr_we = 1'b0; // anything else retires as a no-op.
        end
    end

    assign raddr1 = inst[9:5];
    assign raddr2 = rd_is_src2 ? inst[4:0] : inst[14:10];
    assign dest   = (branch_kind == BR_BL) ? 5'd1 : inst[4:0]; // bl links through r1.

endmodule

//--- pc_unit.sv
`timescale 1ns/10ps

module pc_unit #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pc_update,
    input  cpu_pkg::branch_kind_t branch_kind,
    input  cpu_pkg::word_t        rdata1,
    input  cpu_pkg::word_t        rdata2,
    input  cpu_pkg::word_t        br_offs,
    output cpu_pkg::word_t        pc
);

    import cpu_pkg::*;

    word_t seq_pc;
    word_t next_pc;
    logic  rj_eq_rd;

    assign seq_pc   = pc + 32'd4;
    assign rj_eq_rd = (rdata1 == rdata2);

    always_comb begin
        case (branch_kind)
            BR_B, BR_BL: next_pc = pc + br_offs;
            BR_BEQ:      next_pc = rj_eq_rd ? pc + br_offs : seq_pc;
            BR_BNE:      next_pc = rj_eq_rd ? seq_pc : pc + br_offs;
            BR_JIRL:     next_pc = rdata1 + br_offs; // rj is read before the link write lands.
            default:     next_pc = seq_pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_update) begin
            pc <= next_pc;
        end
    end

endmodule

//--- regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);

    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 never holds a value, so it is forced to zero on the way out.
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0; // released just after an edge like the other stimulus.
    end

endmodule

//--- tb_cpu_top.sv
`timescale 1ns/10ps

module tb_cpu_top;

    import cpu_pkg::*;

    localparam word_t RESET_PC = RESET_PC_DEFAULT;
    localparam int    TIMEOUT  = 200;

    logic       clk, por_reset, test_reset, reset;
    logic       inst_cyc, inst_stb, inst_ack, data_cyc, data_stb, data_we, data_ack;
    word_t      inst_adr, inst_rdata, data_adr, data_wdata, data_rdata;
    word_t      debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_we;
    logic [4:0] debug_wb_rf_wnum;

    word_t imem [64];
    word_t dmem [256];
    word_t ref_dmem [256];
    word_t ref_regs [32];
    word_t ref_pc;
    word_t rng = 32'hc96d_a62b;
    int    inst_wait, data_wait, prog_len, errors, tests_run, tests_failed;

    tb_clock_gen clock_gen_i (.clk(clk), .reset(por_reset));

    assign reset = por_reset | test_reset;

    cpu_top #(.RESET_PC(RESET_PC)) cpu_top_i (.*);

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int draw_wait();
        rng = xorshift(rng);
        return int'(rng[1:0]);
    endfunction

    function automatic word_t mem_fill(input word_t adr);
        return (adr * 32'h9e37_79b9) ^ 32'h0bad_f00d;
    endfunction

    function automatic word_t fetch_word(input word_t adr);
        word_t idx;
        idx = (adr - RESET_PC) >> 2;
        return (idx < 64) ? imem[idx] : 32'h0; // past the program every word is a no-op.
    endfunction

    // ########################################
    // wishbone slaves, 0 to 3 wait cycles.
    // ########################################
    always @(posedge clk) begin
        #1;
        if (inst_ack) begin
            inst_ack = 1'b0;
        end else if (inst_cyc && inst_stb) begin
            if (inst_wait == 0) begin
                inst_rdata = fetch_word(inst_adr);
                inst_ack   = 1'b1;
                inst_wait  = draw_wait();
            end else begin
                inst_wait = inst_wait - 1;
            end
        end
        if (data_ack) begin
            data_ack = 1'b0;
        end else if (data_cyc && data_stb) begin
            if (data_wait == 0) begin
                if (data_adr[31:10] != 22'h0) begin
                    $display("data bus access at %h is outside the data memory", data_adr);
                    errors++;
                end else if (data_we) begin
                    dmem[data_adr[9:2]] = data_wdata;
                end else begin
                    data_rdata = dmem[data_adr[9:2]];
                end
                data_ack  = 1'b1;
                data_wait = draw_wait();
            end else begin
                data_wait = data_wait - 1;
            end
        end
    end

    // instruction formats of the integer subset.
    function automatic word_t three_reg(input logic [16:0] op, input int rd, input int rj,
                                        input int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t reg_imm12(input logic [9:0] op, input int rd, input int rj,
                                        input int imm);
        return {op, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t upper_imm(input int rd, input int imm);
        return {7'h0a, imm[19:0], rd[4:0]};
    endfunction

    function automatic word_t reg_offs16(input logic [5:0] op, input int rd, input int rj,
                                         input int offs);
        return {op, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t long_jump(input logic [5:0] op, input int offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
        end
        prog_len = 0;
    endtask

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // ########################################
    // reference model of the instruction set.
    // ########################################
    // kind is 1 for a register write, 2 for a store and 0 for nothing visible.
    task automatic model_step(output int kind, output logic [4:0] wnum, output word_t wdata,
                              output word_t adr, output word_t pc);
        word_t ir, rj, rk, rd, si12, offs16;
        ir     = fetch_word(ref_pc);
        rj     = ref_regs[ir[9:5]];
        rk     = ref_regs[ir[14:10]];
        rd     = ref_regs[ir[4:0]];
        si12   = {{20{ir[21]}}, ir[21:10]};
        offs16 = {{14{ir[25]}}, ir[25:10], 2'b00};
        pc     = ref_pc;
        ref_pc = pc + 4;
        kind   = 1;
        wnum   = ir[4:0];
        wdata  = '0;
        adr    = rj + si12;
        case (ir[31:15])
            17'h00020: wdata = rj + rk;
            17'h00022: wdata = rj - rk;
            17'h00024: wdata = ($signed(rj) < $signed(rk)) ? 1 : 0;
            17'h00025: wdata = (rj < rk) ? 1 : 0;
            17'h00028: wdata = ~(rj | rk);
            17'h00029: wdata = rj & rk;
            17'h0002a: wdata = rj | rk;
            17'h0002b: wdata = rj ^ rk;
            17'h00081: wdata = rj << ir[14:10];
            17'h00089: wdata = rj >> ir[14:10];
            17'h00091: wdata = $signed(rj) >>> ir[14:10];
            default: begin
                if (ir[31:22] == 10'h00a) begin
                    wdata = rj + si12;
                end else if (ir[31:25] == 7'h0a) begin
                    wdata = {ir[24:5], 12'h000};
                end else if (ir[31:22] == 10'h0a2) begin
                    wdata = ref_dmem[adr[9:2]];
                end else if (ir[31:22] == 10'h0a6) begin
                    kind               = 2;
                    wdata              = rd;
                    ref_dmem[adr[9:2]] = rd;
                end else if (ir[31:26] == 6'h13) begin
                    wdata  = pc + 4;
                    ref_pc = rj + offs16;
                end else if (ir[31:27] == 5'h0a) begin
                    kind   = ir[26] ? 1 : 0; // only bl links, and always into r1.
                    wnum   = 5'd1;
                    wdata  = pc + 4;
                    ref_pc = pc + {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};
                end else if (ir[31:27] == 5'h0b) begin
                    kind = 0;
                    if ((rj == rd) != ir[26]) begin
                        ref_pc = pc + offs16;
                    end
                end else begin
                    kind = 0;
                end
            end
        endcase
        if (kind == 1 && wnum != 5'd0) begin
            ref_regs[wnum] = wdata;
        end
    endtask

    task automatic check_value(input string name, input string what, input word_t expected,
                               input word_t actual);
        if (actual !== expected) begin
            $display("ERR %s: %s expected %h actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    // samples the trace port and the data bus at the falling edge.
    task automatic wait_event(output int kind);
        kind = -1;
        for (int n = 0; n < TIMEOUT && kind < 0; n++) begin
            @(negedge clk);
            if (debug_wb_rf_we != 4'h0) begin
                kind = 1;
            end else if (data_cyc && data_ack && data_we) begin
                kind = 2;
            end
        end
    endtask

    task automatic run_program(input string name, input int events);
        int         start, kind, got;
        logic [4:0] wnum;
        word_t      wdata, adr, pc;
        start = errors;
        tests_run++;
        @(posedge clk);
        #1 test_reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 test_reset = 1'b0;
        ref_pc = RESET_PC;
        got    = 0;
        for (int n = 0; n < TIMEOUT && !got; n++) begin
            @(negedge clk);
            got = inst_cyc;
        end
        if (!got) begin
            $display("%s: the core never started a fetch after reset", name);
            errors++;
        end else begin
            check_value(name, "first fetch address", RESET_PC, inst_adr);
        end
        for (int i = 0; i < events && got; i++) begin
            kind = 0;
            for (int n = 0; n < 64 && kind == 0; n++) begin
                model_step(kind, wnum, wdata, adr, pc);
            end
            wait_event(got);
            if (got < 0) begin
                $display("%s: timed out waiting for retirement %0d", name, i);
                errors++;
                break;
            end
            if (got != kind) begin
                $display("%s: event %0d on the trace and data bus is not the expected one",
                         name, i);
                errors++;
                break;
            end
            if (kind == 1) begin
                check_value(name, "debug_wb_pc", pc, debug_wb_pc);
                check_value(name, "debug_wb_rf_we", 32'hf, {28'h0, debug_wb_rf_we});
                check_value(name, "debug_wb_rf_wnum", {27'h0, wnum}, {27'h0, debug_wb_rf_wnum});
                check_value(name, "debug_wb_rf_wdata", wdata, debug_wb_rf_wdata);
            end else begin
                check_value(name, "data_adr", adr, data_adr);
                check_value(name, "data_wdata", wdata, data_wdata);
            end
        end
        if (errors == start) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - start);
            tests_failed++;
        end
    endtask

    // ########################################
    // directed tests.
    // ########################################
    task automatic arith_test();
        clear_program();
        emit(upper_imm(4, 'h80000));
        emit(reg_imm12(10'h00a, 4, 4, 5));       // r4 = 0x80000005.
        emit(reg_imm12(10'h00a, 5, 0, -3));
        emit(upper_imm(6, 'h12345));
        emit(reg_imm12(10'h00a, 6, 6, 'h678));
        emit(three_reg(17'h00020, 7, 6, 5));     // add.w
        emit(three_reg(17'h00022, 8, 5, 6));     // sub.w
        emit(three_reg(17'h00024, 9, 4, 5));     // slt of two negative values.
        emit(three_reg(17'h00024, 10, 6, 5));
        emit(three_reg(17'h00025, 11, 6, 5));    // sltu
        emit(three_reg(17'h00025, 12, 5, 4));
        emit(three_reg(17'h00028, 13, 6, 5));    // nor
        emit(three_reg(17'h00029, 14, 6, 7));    // and
        emit(three_reg(17'h0002a, 15, 4, 6));    // or
        emit(three_reg(17'h0002b, 16, 6, 5));    // xor
        run_program("arith", 15);
    endtask

    task automatic shift_test();
        clear_program();
        emit(upper_imm(4, 'h80001));
        emit(reg_imm12(10'h00a, 4, 4, 'h7ff));
        emit(reg_imm12(10'h00a, 5, 0, -2048));   // most negative immediate.
        emit(three_reg(17'h00081, 6, 4, 0));
        emit(three_reg(17'h00081, 7, 4, 1));
        emit(three_reg(17'h00081, 8, 4, 31));
        emit(three_reg(17'h00089, 9, 4, 0));
        emit(three_reg(17'h00089, 10, 4, 1));
        emit(three_reg(17'h00089, 11, 4, 31));
        emit(three_reg(17'h00091, 12, 4, 0));
        emit(three_reg(17'h00091, 13, 4, 1));
        emit(three_reg(17'h00091, 14, 4, 31));
        run_program("shift", 12);
    endtask

    task automatic memory_test();
        clear_program();
        emit(reg_imm12(10'h00a, 4, 0, 'h100));   // base address.
        emit(upper_imm(5, 'hdeadb));
        emit(reg_imm12(10'h00a, 5, 5, 'h0ef));
        emit(reg_imm12(10'h0a6, 5, 4, 0));
        emit(reg_imm12(10'h00a, 6, 0, -1));
        emit(reg_imm12(10'h0a6, 6, 4, 8));
        emit(reg_imm12(10'h0a2, 7, 4, 0));
        emit(reg_imm12(10'h0a2, 8, 4, 8));
        emit(reg_imm12(10'h0a2, 9, 4, 4));       // never stored, reads the fill.
        emit(reg_imm12(10'h0a6, 7, 4, -4));
        emit(reg_imm12(10'h0a2, 10, 4, -4));
        run_program("memory", 11);
    endtask

    task automatic branch_test();
        clear_program();
        emit(reg_imm12(10'h00a, 4, 0, 7));
        emit(reg_imm12(10'h00a, 5, 0, 7));
        emit(reg_offs16(6'h16, 5, 4, 2));        // beq taken.
        emit(reg_imm12(10'h00a, 6, 0, 1));
        emit(reg_offs16(6'h17, 5, 4, 2));        // bne not taken.
        emit(reg_imm12(10'h00a, 6, 0, 2));
        emit(reg_imm12(10'h00a, 5, 0, 8));
        emit(reg_offs16(6'h16, 5, 4, 2));        // beq not taken.
        emit(reg_offs16(6'h17, 5, 4, 2));        // bne taken.
        emit(reg_imm12(10'h00a, 7, 0, 1));
        emit(long_jump(6'h14, 2));
        emit(reg_imm12(10'h00a, 7, 0, 2));
        emit(long_jump(6'h15, 3));               // bl, returns to the next word.
        emit(reg_imm12(10'h00a, 8, 0, 3));
        emit(long_jump(6'h14, 0));
        emit(reg_imm12(10'h00a, 9, 0, 4));
        emit(reg_offs16(6'h13, 0, 1, 0));        // jirl r0, r1, 0.
        run_program("branch", 8);
    endtask

    task automatic zero_reg_test();
        clear_program();
        emit(reg_imm12(10'h00a, 0, 0, 'h55));
        emit(three_reg(17'h00020, 4, 0, 0));
        emit(reg_imm12(10'h00a, 5, 0, 'h12));
        emit(three_reg(17'h0002a, 6, 0, 5));
        run_program("zero_reg", 4);
    endtask

    initial begin
        test_reset = 1'b0;
        inst_ack   = 1'b0;
        inst_rdata = '0;
        data_ack   = 1'b0;
        data_rdata = '0;
        inst_wait  = draw_wait();
        data_wait  = draw_wait();
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i]     = mem_fill(i * 4);
            ref_dmem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        @(posedge clk);
        for (int n = 0; n < TIMEOUT && reset; n++) begin
            @(posedge clk);
        end
        if (reset) begin
            $display("reset was never released");
            errors++;
        end
        arith_test();
        shift_test();
        memory_test();
        branch_test();
        zero_reg_test();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
